//--- rgbw_pkg.sv
// shared types, decoder state enum, frame and prescaler constants
package rgbw_pkg;

    // colour, brightness or duty level
    typedef logic [7:0] level_t;

    // pwm phase counter
    typedef logic [7:0] pwm_cnt_t;

    // byte position inside a frame, saturates at 7
    typedef logic [2:0] byte_idx_t;

    // channel number: red, green, blue, white
    typedef logic [1:0] chan_idx_t;

    // frame decoder states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RECV  = 2'd1,
        SCALE = 2'd2,
        LOAD  = 2'd3
    } dec_state_t;

    // brightness byte plus four colour levels
    localparam byte_idx_t FRAME_BYTES = 3'd5;

    // red, green, blue, white
    localparam int unsigned NUM_CHAN = 4;
    localparam chan_idx_t LAST_CHAN = chan_idx_t'(NUM_CHAN - 1);

    // clocks per pwm step
    localparam int unsigned PRESC_DIV = 4;
    localparam int unsigned PRESC_W = $clog2(PRESC_DIV);

    // prescaler count and its terminal value
    typedef logic [PRESC_W-1:0] presc_cnt_t;
    localparam presc_cnt_t PRESC_LAST = presc_cnt_t'(PRESC_DIV - 1);

endpackage

//--- spi_byte_rx.sv
// spi mode-0 byte receiver with pin synchronizers, ready pulse and cs edge pulses
module spi_byte_rx (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             sck,
    input  logic             cs,
    input  logic             mosi,
    output rgbw_pkg::level_t byte_data,
    output logic             byte_rdy,
    output logic             cs_start,
    output logic             cs_end
);

    // two sync flops per pin, third flop on sck and cs for edge detect
    logic [2:0] sck_sync;
    logic [2:0] cs_sync;
    logic [1:0] mosi_sync;
    // bits already taken in the current byte
    logic [2:0] bit_cnt;
    // first seven bits of the byte, msb first
    logic [6:0] shift_q;
    logic       sck_rise;
    logic       cs_low;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sck_sync  <= '0;
            // cs idles high
            cs_sync   <= '1;
            mosi_sync <= '0;
        end else begin
            sck_sync  <= {sck_sync[1:0], sck};
            cs_sync   <= {cs_sync[1:0], cs};
            mosi_sync <= {mosi_sync[0], mosi};
        end
    end

    // mode 0, sample on rising sck
    assign sck_rise = sck_sync[1] & ~sck_sync[2];
    assign cs_low   = ~cs_sync[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt   <= '0;
            byte_data <= '0;
            byte_rdy  <= 1'b0;
            cs_start  <= 1'b0;
            cs_end    <= 1'b0;
        end else begin
            byte_rdy <= 1'b0;
            // falling cs opens a frame, rising cs closes it
            cs_start <= cs_sync[2] & ~cs_sync[1];
            cs_end   <= ~cs_sync[2] & cs_sync[1];
            if (!cs_low) begin
                // deselected, restart on the next frame
                bit_cnt <= '0;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    // eighth edge completes the byte
                    byte_data <= {shift_q, mosi_sync[1]};
                    byte_rdy  <= 1'b1;
                end
            end
        end
    end

    // shift path, contents only matter once bit_cnt reaches 7
    always_ff @(posedge clk) begin
        if (cs_low && sck_rise) begin
            shift_q <= {shift_q[5:0], mosi_sync[1]};
        end
    end

endmodule

//--- rgbw_frame_decoder.sv
// frame decoder: byte counting, raw level storage, brightness scaling, duty load
module rgbw_frame_decoder (
    input  logic             clk,
    input  logic             rst_n,
    input  rgbw_pkg::level_t byte_data,
    input  logic             byte_rdy,
    input  logic             cs_start,
    input  logic             cs_end,
    output rgbw_pkg::level_t duty_r,
    output rgbw_pkg::level_t duty_g,
    output rgbw_pkg::level_t duty_b,
    output rgbw_pkg::level_t duty_w,
    output logic             duty_load,
    output logic             frame_err
);

    rgbw_pkg::dec_state_t state;
    rgbw_pkg::byte_idx_t  byte_cnt;
    // channel being scaled
    rgbw_pkg::chan_idx_t  chan;
    rgbw_pkg::level_t     bright;
    rgbw_pkg::level_t     raw [rgbw_pkg::NUM_CHAN];
    // scaled red, green, blue; white goes straight to its duty
    rgbw_pkg::level_t     shadow [rgbw_pkg::NUM_CHAN-1];
    logic [15:0]          product;
    logic                 last_chan;

    // single shared 8x8 multiplier, one channel per scale cycle
    assign product   = raw[chan] * bright;
    assign last_chan = (chan == rgbw_pkg::LAST_CHAN);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= rgbw_pkg::IDLE;
            byte_cnt  <= '0;
            chan      <= '0;
            duty_r    <= '0;
            duty_g    <= '0;
            duty_b    <= '0;
            duty_w    <= '0;
            duty_load <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            duty_load <= 1'b0;
            case (state)
                rgbw_pkg::IDLE: begin
                    if (cs_start) begin
                        byte_cnt <= '0;
                        state    <= rgbw_pkg::RECV;
                    end
                end
                rgbw_pkg::RECV: begin
                    if (cs_end) begin
                        if (byte_cnt == rgbw_pkg::FRAME_BYTES) begin
                            chan  <= '0;
                            state <= rgbw_pkg::SCALE;
                        end else begin
                            // wrong length, duties stay as they are
                            frame_err <= 1'b1;
                            state     <= rgbw_pkg::IDLE;
                        end
                    end else if (cs_start) begin
                        byte_cnt <= '0;
                    end else if (byte_rdy && byte_cnt != '1) begin
                        // saturate so long frames still count as bad
                        byte_cnt <= byte_cnt + 3'd1;
                    end
                end
                rgbw_pkg::SCALE: begin
                    chan <= chan + 2'd1;
                    if (last_chan) begin
                        // all four duties change together with the load pulse
                        duty_r    <= shadow[0];
                        duty_g    <= shadow[1];
                        duty_b    <= shadow[2];
                        duty_w    <= product[15:8];
                        duty_load <= 1'b1;
                        frame_err <= 1'b0;
                        state     <= rgbw_pkg::LOAD;
                    end
                end
                rgbw_pkg::LOAD: begin
                    // load cycle, cs_start seen here is dropped
                    state <= rgbw_pkg::IDLE;
                end
                default: state <= rgbw_pkg::IDLE;
            endcase
        end
    end

    // frame payload and scaled results
    always_ff @(posedge clk) begin
        if (state == rgbw_pkg::RECV && byte_rdy && !cs_end) begin
            if (byte_cnt == '0) begin
                bright <= byte_data;
            end else if (byte_cnt < rgbw_pkg::FRAME_BYTES) begin
                raw[rgbw_pkg::chan_idx_t'(byte_cnt - 3'd1)] <= byte_data;
            end
        end
        // upper byte of level times brightness
        if (state == rgbw_pkg::SCALE && !last_chan) begin
            shadow[chan] <= product[15:8];
        end
    end

endmodule

//--- pwm_prescaler.sv
// pwm step prescaler, one enable pulse every PRESC_DIV clocks
module pwm_prescaler (
    input  logic clk,
    input  logic rst_n,
    input  logic enable,
    output logic step_en
);

    rgbw_pkg::presc_cnt_t cnt;
    logic                 at_last;

    assign at_last = (cnt == rgbw_pkg::PRESC_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= '0;
            step_en <= 1'b0;
        end else if (!enable) begin
            // divider off, hold at zero and keep pwm frozen
            cnt     <= '0;
            step_en <= 1'b0;
        end else begin
            // pulse on terminal count
            step_en <= at_last;
            if (at_last) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

//--- rgbw_pwm_gen.sv
// four-channel 8-bit pwm generator with duty capture and registered outputs
module rgbw_pwm_gen (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             step_en,
    input  rgbw_pkg::level_t duty_r,
    input  rgbw_pkg::level_t duty_g,
    input  rgbw_pkg::level_t duty_b,
    input  rgbw_pkg::level_t duty_w,
    input  logic             duty_load,
    output logic             pwm_r,
    output logic             pwm_g,
    output logic             pwm_b,
    output logic             pwm_w
);

    rgbw_pkg::pwm_cnt_t cnt;
    rgbw_pkg::pwm_cnt_t cnt_nxt;
    // working duties, used from the next step
    rgbw_pkg::level_t   work_r;
    rgbw_pkg::level_t   work_g;
    rgbw_pkg::level_t   work_b;
    rgbw_pkg::level_t   work_w;

    // wraps 255 -> 0 by width
    assign cnt_nxt = cnt + 8'd1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            work_r <= '0;
            work_g <= '0;
            work_b <= '0;
            work_w <= '0;
        end else if (duty_load) begin
            work_r <= duty_r;
            work_g <= duty_g;
            work_b <= duty_b;
            work_w <= duty_w;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt   <= '0;
            pwm_r <= 1'b0;
            pwm_g <= 1'b0;
            pwm_b <= 1'b0;
            pwm_w <= 1'b0;
        end else if (step_en) begin
            cnt <= cnt_nxt;
            // high while phase below duty, duty steps out of 256
            pwm_r <= (cnt_nxt < work_r);
            pwm_g <= (cnt_nxt < work_g);
            pwm_b <= (cnt_nxt < work_b);
            pwm_w <= (cnt_nxt < work_w);
        end
    end

endmodule

//--- tt_um_rgbw_controller.sv
// rgbw led controller tile top: pin map and block wiring
module tt_um_rgbw_controller (
    input  logic [7:0] ui_in,
    output logic [7:0] uo_out,
    input  logic [7:0] uio_in,
    output logic [7:0] uio_out,
    output logic [7:0] uio_oe,
    input  logic       ena,
    input  logic       clk,
    input  logic       rst_n
);

    rgbw_pkg::level_t byte_data;
    logic             byte_rdy;
    logic             cs_start;
    logic             cs_end;
    rgbw_pkg::level_t duty_r;
    rgbw_pkg::level_t duty_g;
    rgbw_pkg::level_t duty_b;
    rgbw_pkg::level_t duty_w;
    logic             duty_load;
    logic             frame_err;
    logic             step_en;
    logic             pwm_r;
    logic             pwm_g;
    logic             pwm_b;
    logic             pwm_w;

    // pins with no function in this tile
    wire unused = &{ui_in[6], ui_in[2:0], uio_in, 1'b0};

    // sck on ui_in[5], cs on ui_in[4] (active low), mosi on ui_in[3]
    spi_byte_rx i_spi_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .sck       (ui_in[5]),
        .cs        (ui_in[4]),
        .mosi      (ui_in[3]),
        .byte_data (byte_data),
        .byte_rdy  (byte_rdy),
        .cs_start  (cs_start),
        .cs_end    (cs_end)
    );

    rgbw_frame_decoder i_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .byte_data (byte_data),
        .byte_rdy  (byte_rdy),
        .cs_start  (cs_start),
        .cs_end    (cs_end),
        .duty_r    (duty_r),
        .duty_g    (duty_g),
        .duty_b    (duty_b),
        .duty_w    (duty_w),
        .duty_load (duty_load),
        .frame_err (frame_err)
    );

    // divider enable on ui_in[7]
    pwm_prescaler i_prescaler (
        .clk     (clk),
        .rst_n   (rst_n),
        .enable  (ui_in[7]),
        .step_en (step_en)
    );

    rgbw_pwm_gen i_pwm (
        .clk       (clk),
        .rst_n     (rst_n),
        .step_en   (step_en),
        .duty_r    (duty_r),
        .duty_g    (duty_g),
        .duty_b    (duty_b),
        .duty_w    (duty_w),
        .duty_load (duty_load),
        .pwm_r     (pwm_r),
        .pwm_g     (pwm_g),
        .pwm_b     (pwm_b),
        .pwm_w     (pwm_w)
    );

    // led pins low nibble, then step, byte ready, frame error, ena
    assign uo_out  = {ena, frame_err, byte_rdy, step_en, pwm_w, pwm_b, pwm_g, pwm_r};
    // last received byte, bidir pins always driven
    assign uio_out = byte_data;
    assign uio_oe  = 8'hff;

endmodule

//--- rgbw_controller_props.sv
// property checker for the rgbw tile: spi byte, frame and pwm reference models with assertions
module rgbw_controller_props (
    input logic       clk,
    input logic       rst_n,
    input logic       ena,
    input logic [7:0] ui_in,
    input logic [7:0] uo_out,
    input logic [7:0] uio_out,
    input logic [7:0] uio_oe
);

    // clocks to wait after a good frame before a period may be measured
    localparam int unsigned SETTLE = 32;

    // previous pin samples
    logic                sck_q;
    logic                cs_q;
    // spi bit model
    logic [2:0]          bit_cnt;
    logic [7:0]          rx_shift;
    logic [7:0]          rx_last;
    logic                rx_done;
    // frame model
    rgbw_pkg::byte_idx_t nbytes;
    rgbw_pkg::level_t    bright;
    rgbw_pkg::level_t    lvl [rgbw_pkg::NUM_CHAN];
    rgbw_pkg::level_t    exp_duty [rgbw_pkg::NUM_CHAN];
    logic                good_end;
    logic                bad_end;
    logic                started;
    // pwm period model
    rgbw_pkg::pwm_cnt_t  ph;
    logic [8:0]          hi_cnt [rgbw_pkg::NUM_CHAN];
    logic [8:0]          meas_hi [rgbw_pkg::NUM_CHAN];
    rgbw_pkg::level_t    per_exp [rgbw_pkg::NUM_CHAN];
    rgbw_pkg::level_t    meas_exp [rgbw_pkg::NUM_CHAN];
    logic                meas_on;
    logic [5:0]          settle;
    logic                period_done;
    int unsigned         period_cnt;
    int unsigned         err_cnt = 0;

    // upper byte of level times brightness
    function automatic rgbw_pkg::level_t scale(input rgbw_pkg::level_t level,
                                               input rgbw_pkg::level_t gain);
        logic [15:0] prod;
        prod = 16'(level) * 16'(gain);
        return prod[15:8];
    endfunction

    // bytes and frames straight from the spi pins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sck_q    <= 1'b0;
            cs_q     <= 1'b1;
            bit_cnt  <= '0;
            rx_shift <= '0;
            rx_last  <= '0;
            rx_done  <= 1'b0;
            nbytes   <= '0;
            bright   <= '0;
            good_end <= 1'b0;
            bad_end  <= 1'b0;
            started  <= 1'b0;
            for (int c = 0; c < rgbw_pkg::NUM_CHAN; c++) begin
                lvl[c]      <= '0;
                exp_duty[c] <= '0;
            end
        end else begin
            sck_q    <= ui_in[5];
            cs_q     <= ui_in[4];
            rx_done  <= 1'b0;
            good_end <= 1'b0;
            bad_end  <= 1'b0;
            // first spi or divider activity ends the quiet phase
            if (!ui_in[4] || ui_in[7]) begin
                started <= 1'b1;
            end
            if (ui_in[4]) begin
                bit_cnt <= '0;
            end else if (ui_in[5] && !sck_q) begin
                bit_cnt  <= bit_cnt + 3'd1;
                rx_shift <= {rx_shift[6:0], ui_in[3]};
                if (bit_cnt == 3'd7) begin
                    rx_last <= {rx_shift[6:0], ui_in[3]};
                    rx_done <= 1'b1;
                end
            end
            if (cs_q && !ui_in[4]) begin
                nbytes <= '0;
            end else if (!ui_in[4] && rx_done && nbytes != '1) begin
                // byte 0 is brightness, then red, green, blue, white
                if (nbytes == '0) begin
                    bright <= rx_last;
                end else if (nbytes < rgbw_pkg::FRAME_BYTES) begin
                    lvl[2'(nbytes - 3'd1)] <= rx_last;
                end
                nbytes <= nbytes + 3'd1;
            end else if (!cs_q && ui_in[4]) begin
                if (nbytes == rgbw_pkg::FRAME_BYTES) begin
                    for (int c = 0; c < rgbw_pkg::NUM_CHAN; c++) begin
                        exp_duty[c] <= scale(lvl[c], bright);
                    end
                    good_end <= 1'b1;
                end else begin
                    bad_end <= 1'b1;
                end
            end
        end
    end

    // count pin-high steps from one counter wrap to the next
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ph          <= '0;
            meas_on     <= 1'b0;
            settle      <= '0;
            period_done <= 1'b0;
            period_cnt  <= 0;
            for (int c = 0; c < rgbw_pkg::NUM_CHAN; c++) begin
                hi_cnt[c]   <= '0;
                meas_hi[c]  <= '0;
                per_exp[c]  <= '0;
                meas_exp[c] <= '0;
            end
        end else begin
            period_done <= 1'b0;
            if (good_end) begin
                // new duties pending, drop the running period
                settle  <= 6'(SETTLE);
                meas_on <= 1'b0;
            end else if (settle != '0) begin
                settle <= settle - 6'd1;
            end
            if (uo_out[4]) begin
                ph <= ph + 8'd1;
                if (ph == '0) begin
                    if (meas_on && !good_end) begin
                        period_done <= 1'b1;
                        period_cnt  <= period_cnt + 1;
                        meas_hi     <= hi_cnt;
                        meas_exp    <= per_exp;
                    end
                    meas_on <= (settle == '0) && !good_end;
                    for (int c = 0; c < rgbw_pkg::NUM_CHAN; c++) begin
                        hi_cnt[c]  <= 9'(uo_out[c]);
                        per_exp[c] <= exp_duty[c];
                    end
                end else begin
                    for (int c = 0; c < rgbw_pkg::NUM_CHAN; c++) begin
                        hi_cnt[c] <= hi_cnt[c] + 9'(uo_out[c]);
                    end
                end
            end
        end
    end

    // tile stays quiet until the first stimulus
    a_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> (uo_out[6:0] == 7'h00 && uio_out == 8'h00))
        else begin
            err_cnt++;
            $error("CHECK FAILED uo_out[6:0] exp 00 got %02h, uio_out exp 00 got %02h",
                   $sampled(uo_out[6:0]), $sampled(uio_out));
        end

    // ena mirror and bidir pins always driven
    a_pins: assert property (@(posedge clk) disable iff (!rst_n)
        uo_out[7] == ena && uio_oe == 8'hff)
        else begin
            err_cnt++;
            $error("CHECK FAILED uo_out[7] exp %01h got %01h, uio_oe exp ff got %02h",
                   $sampled(ena), $sampled(uo_out[7]), $sampled(uio_oe));
        end

    // every byte on the pins gets a ready pulse
    a_rdy_seen: assert property (@(posedge clk) disable iff (!rst_n)
        rx_done |-> ##[1:6] uo_out[5])
        else begin
            err_cnt++;
            $error("no ready pulse on uo_out[5] after a complete spi byte");
        end

    a_rdy_single: assert property (@(posedge clk) disable iff (!rst_n)
        uo_out[5] |=> !uo_out[5])
        else begin
            err_cnt++;
            $error("CHECK FAILED uo_out[5] exp 0 got 1");
        end

    a_byte_val: assert property (@(posedge clk) disable iff (!rst_n)
        uo_out[5] |-> uio_out == rx_last)
        else begin
            err_cnt++;
            $error("CHECK FAILED uio_out exp %02h got %02h",
                   $sampled(rx_last), $sampled(uio_out));
        end

    // last byte held between ready pulses
    a_byte_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !uo_out[5] |-> $stable(uio_out))
        else begin
            err_cnt++;
            $error("CHECK FAILED uio_out exp %02h got %02h",
                   $past(uio_out), $sampled(uio_out));
        end

    a_err_set: assert property (@(posedge clk) disable iff (!rst_n)
        bad_end |-> ##[1:12] uo_out[6])
        else begin
            err_cnt++;
            $error("CHECK FAILED uo_out[6] exp 1 got 0");
        end

    a_err_clear: assert property (@(posedge clk) disable iff (!rst_n)
        good_end |-> ##[1:12] !uo_out[6])
        else begin
            err_cnt++;
            $error("CHECK FAILED uo_out[6] exp 0 got 1");
        end

    // step enable spacing and period
    a_step_gap: assert property (@(posedge clk) disable iff (!rst_n)
        uo_out[4] |=> !uo_out[4] [*(rgbw_pkg::PRESC_DIV - 1)])
        else begin
            err_cnt++;
            $error("CHECK FAILED uo_out[4] exp 0 got 1");
        end

    a_step_period: assert property (@(posedge clk) disable iff (!rst_n)
        uo_out[4] && ui_in[7] ##1 ui_in[7] [*(rgbw_pkg::PRESC_DIV - 1)] |=> uo_out[4])
        else begin
            err_cnt++;
            $error("CHECK FAILED uo_out[4] exp 1 got 0");
        end

    // divider off freezes steps and pins
    a_freeze: assert property (@(posedge clk) disable iff (!rst_n)
        !ui_in[7] |=> !uo_out[4] ##1 $stable(uo_out[3:0]))
        else begin
            err_cnt++;
            $error("CHECK FAILED uo_out[4:0] exp %02h got %02h",
                   {1'b0, $past(uo_out[3:0])}, $sampled(uo_out[4:0]));
        end

    for (genvar c = 0; c < rgbw_pkg::NUM_CHAN; c++) begin : g_duty
        // high steps per full period equal the scaled duty
        a_duty: assert property (@(posedge clk) disable iff (!rst_n)
            period_done |-> meas_hi[c] == {1'b0, meas_exp[c]})
            else begin
                err_cnt++;
                $error("CHECK FAILED uo_out[%0d] high steps exp %03h got %03h",
                       c, $sampled(meas_exp[c]), $sampled(meas_hi[c]));
            end
    end

endmodule

//--- tb_rgbw_controller.sv
// testbench for the rgbw tile: clock, reset, spi frame stimulus, timeouts, result
module tb_rgbw_controller;

    localparam int unsigned SCK_HALF       = 8;
    localparam int unsigned RDY_TIMEOUT    = 64;
    localparam int unsigned FLAG_TIMEOUT   = 64;
    localparam int unsigned PERIOD_TIMEOUT = 4096;

    typedef logic [7:0] byte_q_t [$];

    logic       clk = 1'b0;
    logic       rst_n;
    logic       ena;
    logic [7:0] ui_in;
    logic [7:0] uio_in;
    logic [7:0] uo_out;
    logic [7:0] uio_out;
    logic [7:0] uio_oe;

    // 4 time unit clock
    always #2 clk = ~clk;

    tt_um_rgbw_controller i_dut (
        .ui_in   (ui_in),
        .uo_out  (uo_out),
        .uio_in  (uio_in),
        .uio_out (uio_out),
        .uio_oe  (uio_oe),
        .ena     (ena),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    bind tt_um_rgbw_controller rgbw_controller_props i_props (
        .clk     (clk),
        .rst_n   (rst_n),
        .ena     (ena),
        .ui_in   (ui_in),
        .uo_out  (uo_out),
        .uio_out (uio_out),
        .uio_oe  (uio_oe)
    );

    task automatic stop_with_failure(input string why);
        $display("Testbench failed");
        $fatal(1, "%s", why);
    endtask

    // first assertion failure ends the run
    always @(posedge clk) begin
        if (i_dut.i_props.err_cnt != 0) begin
            stop_with_failure("an assertion in the property checker failed");
        end
    end

    task automatic wait_byte_rdy();
        int unsigned n;
        n = 0;
        while (uo_out[5] !== 1'b1) begin
            if (n == RDY_TIMEOUT) begin
                stop_with_failure("timed out waiting for the byte ready pulse");
            end
            n++;
            @(posedge clk);
        end
    endtask

    task automatic wait_frame_err(input logic level);
        int unsigned n;
        n = 0;
        while (uo_out[6] !== level) begin
            if (n == FLAG_TIMEOUT) begin
                stop_with_failure("timed out waiting for the frame error flag to settle");
            end
            n++;
            @(posedge clk);
        end
    endtask

    // one more pwm period measured by the checker
    task automatic wait_checked_period();
        int unsigned start;
        int unsigned n;
        start = i_dut.i_props.period_cnt;
        n = 0;
        while (i_dut.i_props.period_cnt == start) begin
            if (n == PERIOD_TIMEOUT) begin
                stop_with_failure("timed out waiting for a full pwm period");
            end
            n++;
            @(posedge clk);
        end
    endtask

    // mode 0, msb first, mosi set while sck is low
    task automatic send_byte(input logic [7:0] b);
        for (int i = 7; i >= 0; i--) begin
            @(posedge clk);
            ui_in[5] <= 1'b0;
            ui_in[3] <= b[i];
            repeat (SCK_HALF) @(posedge clk);
            ui_in[5] <= 1'b1;
            if (i == 0) begin
                wait_byte_rdy();
            end
            repeat (SCK_HALF) @(posedge clk);
        end
        @(posedge clk);
        ui_in[5] <= 1'b0;
    endtask

    task automatic send_frame(input byte_q_t bytes);
        @(posedge clk);
        ui_in[4] <= 1'b0;
        repeat (SCK_HALF) @(posedge clk);
        foreach (bytes[i]) begin
            send_byte(bytes[i]);
        end
        repeat (SCK_HALF) @(posedge clk);
        ui_in[4] <= 1'b1;
        repeat (2 * SCK_HALF) @(posedge clk);
    endtask

    task automatic send_random_frame(input int unsigned len);
        byte_q_t q;
        q = {};
        repeat (len) q.push_back(8'($urandom()));
        send_frame(q);
    endtask

    initial begin
        void'($urandom(48608));
        rst_n  = 1'b0;
        ena    = 1'b1;
        // cs idles high
        ui_in  = 8'h10;
        uio_in = 8'h00;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        // quiet tile after reset, ena only reaches uo_out[7]
        repeat (4) @(posedge clk);
        ena <= 1'b0;
        repeat (4) @(posedge clk);
        ena <= 1'b1;
        repeat (4) @(posedge clk);

        ui_in[7] <= 1'b1;
        send_random_frame(rgbw_pkg::FRAME_BYTES);
        wait_frame_err(1'b0);
        wait_checked_period();

        // short and long frames keep the old duties
        send_random_frame(3);
        wait_frame_err(1'b1);
        wait_checked_period();
        send_random_frame(7);
        wait_frame_err(1'b1);
        wait_checked_period();

        // full and zero levels, clears the error
        send_frame('{8'hff, 8'hff, 8'h00, 8'h80, 8'h01});
        wait_frame_err(1'b0);
        wait_checked_period();

        send_random_frame(rgbw_pkg::FRAME_BYTES);
        wait_frame_err(1'b0);
        // divider off in mid period
        repeat (300) @(posedge clk);
        ui_in[7] <= 1'b0;
        repeat (40) @(posedge clk);
        ui_in[7] <= 1'b1;
        wait_checked_period();
        wait_checked_period();

        repeat (8) @(posedge clk);
        if (i_dut.i_props.err_cnt == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            stop_with_failure("the property checker counted errors");
        end
    end

endmodule

//--- src.f
rgbw_pkg.sv
spi_byte_rx.sv
rgbw_frame_decoder.sv
pwm_prescaler.sv
rgbw_pwm_gen.sv
tt_um_rgbw_controller.sv
rgbw_controller_props.sv
tb_rgbw_controller.sv

//--- Bender.yml
package:
  name: rgbw_controller

sources:
  - rgbw_pkg.sv
  - spi_byte_rx.sv
  - rgbw_frame_decoder.sv
  - pwm_prescaler.sv
  - rgbw_pwm_gen.sv
  - tt_um_rgbw_controller.sv
  - target: simulation
    files:
      - rgbw_controller_props.sv
      - tb_rgbw_controller.sv
